// ==== design/dma_axis_fifo.sv ====
`timescale 1ns/1ps

module dma_axis_fifo #(
    parameter type         element_t = logic [7:0],
    parameter int unsigned Depth     = 4
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    // Push side
    input  element_t data_i,
    input  logic     valid_i,
    output logic     ready_o,
    // Pop side
    output element_t data_o,
    output logic     valid_o,
    input  logic     ready_i
);
    localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntWidth = $clog2(Depth + 1);

    typedef logic [PtrWidth-1:0] ptr_t;
    typedef logic [CntWidth-1:0] cnt_t;

    // Storage
    element_t mem_q [Depth];
    ptr_t     wr_ptr_q;
    ptr_t     rd_ptr_q;
    cnt_t     count_q;
    logic     push;
    logic     pop;

    // Wrap at Depth, which need not be a power of two
    function automatic ptr_t ptr_inc(input ptr_t ptr);
        return (ptr == ptr_t'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Full drops ready, empty drops valid
    assign ready_o = (count_q != cnt_t'(Depth));
    assign valid_o = (count_q != '0);
    assign data_o  = mem_q[rd_ptr_q];

    assign push = valid_i & ready_o;
    assign pop  = valid_o & ready_i;

    // Pointers and fill level
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
            // Simultaneous push and pop leaves the level as is
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Element array
    always_ff @(posedge clk_i) begin
        if (push) mem_q[wr_ptr_q] <= data_i;
    end

endmodule

// ==== design/dma_axis_legalizer.sv ====
`timescale 1ns/1ps

module dma_axis_legalizer #(
    parameter int unsigned StrbWidth = 4
) (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    // Transfer command
    input  dma_axis_pkg::xfer_cmd_t cmd_i,
    input  logic                    cmd_valid_i,
    output logic                    cmd_ready_o,
    // Source beat descriptors
    output dma_axis_pkg::rd_beat_t  rd_beat_o,
    output logic                    rd_valid_o,
    input  logic                    rd_ready_i,
    // Destination beat descriptors
    output dma_axis_pkg::wr_beat_t  wr_beat_o,
    output logic                    wr_valid_o,
    input  logic                    wr_ready_i
);
    localparam int unsigned ShiftBits = $clog2(StrbWidth);
    localparam int unsigned CntWidth  = dma_axis_pkg::LenWidth + 1;
    localparam dma_axis_pkg::offset_t LaneMask = dma_axis_pkg::offset_t'(StrbWidth - 1);

    typedef logic [CntWidth-1:0] cnt_t;

    dma_axis_pkg::xfer_cmd_t cmd_q;
    logic                    busy_q;
    cnt_t                    rd_total_q;
    cnt_t                    wr_total_q;
    cnt_t                    rd_idx_q;
    cnt_t                    wr_idx_q;
    logic                    cmd_take;
    logic                    rd_done;
    logic                    wr_done;

    // Beats covered by offset plus length, rounded up
    function automatic cnt_t beat_count(
        input dma_axis_pkg::offset_t             off,
        input logic [dma_axis_pkg::LenWidth-1:0] len
    );
        cnt_t span;
        span = cnt_t'(off & LaneMask) + cnt_t'(len) + cnt_t'(StrbWidth - 1);
        return span >> ShiftBits;
    endfunction

    // Only idle accepts a new command
    assign cmd_ready_o = ~busy_q;
    assign cmd_take    = cmd_valid_i & cmd_ready_o;

    assign rd_done    = (rd_idx_q == rd_total_q);
    assign wr_done    = (wr_idx_q == wr_total_q);
    assign rd_valid_o = busy_q & ~rd_done;
    assign wr_valid_o = busy_q & ~wr_done;

    // ----------------------------------------
    // Descriptor fields
    // ----------------------------------------
    // First beat starts at the offset, last ends at the tailer
    assign rd_beat_o.offset = (rd_idx_q == '0) ? (cmd_q.src_offset & LaneMask) : '0;
    assign rd_beat_o.tailer = (rd_idx_q == rd_total_q - 1'b1)
        ? ((cmd_q.src_offset + dma_axis_pkg::offset_t'(cmd_q.length)) & LaneMask) : '0;
    assign rd_beat_o.shift  = (cmd_q.dst_offset - cmd_q.src_offset) & LaneMask;

    assign wr_beat_o.offset = (wr_idx_q == '0) ? (cmd_q.dst_offset & LaneMask) : '0;
    assign wr_beat_o.tailer = wr_beat_o.last
        ? ((cmd_q.dst_offset + dma_axis_pkg::offset_t'(cmd_q.length)) & LaneMask) : '0;
    assign wr_beat_o.last   = (wr_idx_q == wr_total_q - 1'b1);
    assign wr_beat_o.dest   = cmd_q.dest;

    // ----------------------------------------
    // Beat counters
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q     <= 1'b0;
            rd_total_q <= '0;
            wr_total_q <= '0;
            rd_idx_q   <= '0;
            wr_idx_q   <= '0;
        end else if (cmd_take) begin
            busy_q     <= 1'b1;
            rd_total_q <= beat_count(cmd_i.src_offset, cmd_i.length);
            wr_total_q <= beat_count(cmd_i.dst_offset, cmd_i.length);
            rd_idx_q   <= '0;
            wr_idx_q   <= '0;
        end else if (busy_q) begin
            // Both walks are independent
            if (rd_valid_o && rd_ready_i) rd_idx_q <= rd_idx_q + 1'b1;
            if (wr_valid_o && wr_ready_i) wr_idx_q <= wr_idx_q + 1'b1;
            if (rd_done && wr_done) busy_q <= 1'b0;
        end
    end

    // Command held for the whole walk
    always_ff @(posedge clk_i) begin
        if (cmd_take) cmd_q <= cmd_i;
    end

endmodule

// ==== design/dma_axis_pkg.sv ====
package dma_axis_pkg;

    // ----------------------------------------
    // Lane limits
    // ----------------------------------------
    // Widest lane bank the control structs can describe
    localparam int unsigned MaxStrbWidth = 16;
    // Lane index width, enough for MaxStrbWidth lanes
    localparam int unsigned OffsetWidth  = 4;
    // Transfer length width in bytes
    localparam int unsigned LenWidth     = 16;

    // Lane index or lane count, modulo the lane count
    typedef logic [OffsetWidth-1:0] offset_t;

    // ----------------------------------------
    // Command and beat descriptors
    // ----------------------------------------
    // Transfer command, 28 bits
    typedef struct packed {
        offset_t             src_offset;
        offset_t             dst_offset;
        // Byte count, never zero
        logic [LenWidth-1:0] length;
        logic [3:0]          dest;
    } xfer_cmd_t;

    // Source beat, 12 bits
    // Tailer of zero means full up to the top lane
    typedef struct packed {
        offset_t offset;
        offset_t tailer;
        // Rotation from source lane to destination lane
        offset_t shift;
    } rd_beat_t;

    // Destination beat, 13 bits
    typedef struct packed {
        offset_t    offset;
        offset_t    tailer;
        logic       last;
        logic [3:0] dest;
    } wr_beat_t;

endpackage

// ==== design/dma_axis_src_read.sv ====
`timescale 1ns/1ps

module dma_axis_src_read #(
    parameter int unsigned StrbWidth = 4
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    // Source beat descriptor
    input  dma_axis_pkg::rd_beat_t       rd_beat_i,
    input  logic                         rd_valid_i,
    output logic                         rd_ready_o,
    // Source word stream
    input  logic [StrbWidth*8-1:0]       src_data_i,
    input  logic                         src_valid_i,
    output logic                         src_ready_o,
    // Lane FIFO push side
    output logic [StrbWidth-1:0][7:0]    lane_data_o,
    output logic [StrbWidth-1:0]         lane_push_o,
    input  logic [StrbWidth-1:0]         lane_space_i
);
    localparam logic [StrbWidth-1:0] AllLanes = {StrbWidth{1'b1}};

    // Lanes of the source word that carry transfer bytes
    logic [StrbWidth-1:0] src_mask;
    // Same mask after rotation onto the lane FIFOs
    logic [StrbWidth-1:0] push_mask;
    logic                 space_ok;
    logic                 accept;
    logic                 armed_q;

    // ----------------------------------------
    // Lane mask
    // ----------------------------------------
    // From offset up to tailer, zero tailer is full
    assign src_mask = (AllLanes << rd_beat_i.offset)
        & ((rd_beat_i.tailer != '0) ? (AllLanes >> (StrbWidth - rd_beat_i.tailer)) : AllLanes);

    // Byte j lands in lane (j + shift) mod StrbWidth
    always_comb begin
        int unsigned src_lane;
        for (int unsigned i = 0; i < StrbWidth; i++) begin
            src_lane       = (i - rd_beat_i.shift) & (StrbWidth - 1);
            lane_data_o[i] = src_data_i[src_lane*8 +: 8];
            push_mask[i]   = src_mask[src_lane];
        end
    end

    // ----------------------------------------
    // Handshake
    // ----------------------------------------
    // Every target lane needs room
    assign space_ok = ((lane_space_i & push_mask) == push_mask);

    // Word and descriptor go together
    assign accept      = armed_q & rd_valid_i & src_valid_i & space_ok;
    assign src_ready_o = armed_q & rd_valid_i & space_ok;
    assign rd_ready_o  = armed_q & src_valid_i & space_ok;
    assign lane_push_o = accept ? push_mask : '0;

    // Intake stays closed for one cycle after reset release
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            armed_q <= 1'b0;
        end else begin
            armed_q <= 1'b1;
        end
    end

endmodule

// ==== design/dma_axis_stream_fork.sv ====
`timescale 1ns/1ps

module dma_axis_stream_fork (
    input  logic       clk_i,
    input  logic       arst_n_i,
    // Upstream handshake
    input  logic       valid_i,
    // Outputs that take part in this transfer
    input  logic [1:0] sel_i,
    output logic       ready_o,
    // Downstream handshakes
    output logic [1:0] valid_o,
    input  logic [1:0] ready_i
);
    // One bit per output, set once that output was taken
    logic [1:0] taken_q;
    logic [1:0] out_done;

    // Outputs left out of the select are treated as taken
    assign valid_o  = {2{valid_i}} & sel_i & ~taken_q;
    assign out_done = taken_q | ~sel_i | ready_i;

    // Acknowledge once the last pending output goes
    assign ready_o = valid_i & (&out_done);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            taken_q <= '0;
        end else if (ready_o) begin
            // Transfer complete, clear for the next one
            taken_q <= '0;
        end else if (valid_i) begin
            taken_q <= taken_q | (valid_o & ready_i);
        end
    end

endmodule

// ==== design/dma_axis_write.sv ====
`timescale 1ns/1ps

module dma_axis_write #(
    parameter int unsigned StrbWidth       = 4,
    parameter bit          MaskInvalidData = 1'b1
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    // Destination beat descriptor
    input  dma_axis_pkg::wr_beat_t    wr_beat_i,
    input  logic                      wr_valid_i,
    output logic                      wr_ready_o,
    // Lane FIFO pop side
    input  logic [StrbWidth-1:0][7:0] lane_data_i,
    input  logic [StrbWidth-1:0]      lane_valid_i,
    output logic [StrbWidth-1:0]      lane_pop_o,
    // AXI Stream manager
    output logic [StrbWidth*8-1:0]    tdata_o,
    output logic [StrbWidth-1:0]      tkeep_o,
    output logic                      tlast_o,
    output logic [3:0]                tdest_o,
    output logic                      tvalid_o,
    input  logic                      tready_i,
    // Transfer done
    output logic                      done_valid_o,
    input  logic                      done_ready_i
);
    localparam logic [StrbWidth-1:0] AllLanes = {StrbWidth{1'b1}};

    // Lanes this beat occupies on the bus
    logic [StrbWidth-1:0] keep_mask;
    // Descriptor present and all its lanes filled
    logic                 ready_to_write;
    // Fork finished, beat leaves
    logic                 write_fire;

    // ----------------------------------------
    // Keep mask
    // ----------------------------------------
    assign keep_mask = (AllLanes << wr_beat_i.offset)
        & ((wr_beat_i.tailer != '0) ? (AllLanes >> (StrbWidth - wr_beat_i.tailer)) : AllLanes);

    // Lanes outside the mask may still hold later bytes
    assign ready_to_write = wr_valid_i & ((lane_valid_i & keep_mask) == keep_mask);

    // ----------------------------------------
    // Stream payload
    // ----------------------------------------
    assign tkeep_o = keep_mask;
    assign tlast_o = wr_beat_i.last;
    assign tdest_o = wr_beat_i.dest;

    if (MaskInvalidData) begin : gen_mask_data
        // Unused lanes driven as zero
        always_comb begin
            for (int unsigned i = 0; i < StrbWidth; i++) begin
                tdata_o[i*8 +: 8] = keep_mask[i] ? lane_data_i[i] : 8'h00;
            end
        end
    end else begin : gen_raw_data
        // Lane outputs straight onto the bus
        assign tdata_o = lane_data_i;
    end

    // ----------------------------------------
    // Pop control
    // ----------------------------------------
    // Exactly the kept lanes, and the descriptor, in the fork's final cycle
    assign lane_pop_o = write_fire ? keep_mask : '0;
    assign wr_ready_o = write_fire;

    // Stream beat always, done only on the last beat
    dma_axis_stream_fork i_write_fork (
        .clk_i    ( clk_i                          ),
        .arst_n_i ( arst_n_i                       ),
        .valid_i  ( ready_to_write                 ),
        .sel_i    ( {wr_beat_i.last, 1'b1}         ),
        .ready_o  ( write_fire                     ),
        .valid_o  ( {done_valid_o, tvalid_o}       ),
        .ready_i  ( {done_ready_i, tready_i}       )
    );

endmodule

// ==== design/dma_axis_xfer.sv ====
`timescale 1ns/1ps

module dma_axis_xfer #(
    parameter int unsigned StrbWidth       = 4,
    parameter int unsigned LaneDepth       = 4,
    parameter int unsigned QueueDepth      = 2,
    parameter bit          MaskInvalidData = 1'b1
) (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    // Command
    input  dma_axis_pkg::xfer_cmd_t cmd_i,
    input  logic                    cmd_valid_i,
    output logic                    cmd_ready_o,
    // Source words
    input  logic [StrbWidth*8-1:0]  src_data_i,
    input  logic                    src_valid_i,
    output logic                    src_ready_o,
    // AXI Stream manager
    output logic [StrbWidth*8-1:0]  tdata_o,
    output logic [StrbWidth-1:0]    tkeep_o,
    output logic                    tlast_o,
    output logic [3:0]              tdest_o,
    output logic                    tvalid_o,
    input  logic                    tready_i,
    // Transfer done
    output logic                    done_valid_o,
    input  logic                    done_ready_i
);
    typedef logic [7:0] byte_t;

    // Legalizer to queues
    dma_axis_pkg::rd_beat_t rd_beat_in, rd_beat_out;
    dma_axis_pkg::wr_beat_t wr_beat_in, wr_beat_out;
    logic rd_in_valid, rd_in_ready, rd_out_valid, rd_out_ready;
    logic wr_in_valid, wr_in_ready, wr_out_valid, wr_out_ready;

    // Lane bank
    byte_t [StrbWidth-1:0] lane_in, lane_out;
    logic  [StrbWidth-1:0] lane_push, lane_space, lane_valid, lane_pop;

    dma_axis_legalizer #(.StrbWidth(StrbWidth)) i_legalizer (
        .clk_i, .arst_n_i, .cmd_i, .cmd_valid_i, .cmd_ready_o,
        .rd_beat_o  ( rd_beat_in  ), .rd_valid_o ( rd_in_valid ), .rd_ready_i ( rd_in_ready ),
        .wr_beat_o  ( wr_beat_in  ), .wr_valid_o ( wr_in_valid ), .wr_ready_i ( wr_in_ready )
    );

    // ----------------------------------------
    // Beat queues
    // ----------------------------------------
    dma_axis_fifo #(.element_t(dma_axis_pkg::rd_beat_t), .Depth(QueueDepth)) i_rd_queue (
        .clk_i, .arst_n_i,
        .data_i  ( rd_beat_in  ), .valid_i ( rd_in_valid  ), .ready_o ( rd_in_ready  ),
        .data_o  ( rd_beat_out ), .valid_o ( rd_out_valid ), .ready_i ( rd_out_ready )
    );

    dma_axis_fifo #(.element_t(dma_axis_pkg::wr_beat_t), .Depth(QueueDepth)) i_wr_queue (
        .clk_i, .arst_n_i,
        .data_i  ( wr_beat_in  ), .valid_i ( wr_in_valid  ), .ready_o ( wr_in_ready  ),
        .data_o  ( wr_beat_out ), .valid_o ( wr_out_valid ), .ready_i ( wr_out_ready )
    );

    dma_axis_src_read #(.StrbWidth(StrbWidth)) i_src_read (
        .clk_i, .arst_n_i,
        .rd_beat_i   ( rd_beat_out  ), .rd_valid_i ( rd_out_valid ), .rd_ready_o ( rd_out_ready ),
        .src_data_i, .src_valid_i, .src_ready_o,
        .lane_data_o ( lane_in      ), .lane_push_o ( lane_push ), .lane_space_i ( lane_space )
    );

    // One byte FIFO per lane
    for (genvar i = 0; i < StrbWidth; i++) begin : gen_lanes
        dma_axis_fifo #(.element_t(byte_t), .Depth(LaneDepth)) i_lane (
            .clk_i, .arst_n_i,
            .data_i  ( lane_in[i]  ), .valid_i ( lane_push[i]  ), .ready_o ( lane_space[i] ),
            .data_o  ( lane_out[i] ), .valid_o ( lane_valid[i] ), .ready_i ( lane_pop[i]   )
        );
    end

    dma_axis_write #(.StrbWidth(StrbWidth), .MaskInvalidData(MaskInvalidData)) i_write (
        .clk_i, .arst_n_i,
        .wr_beat_i   ( wr_beat_out ), .wr_valid_i ( wr_out_valid ), .wr_ready_o ( wr_out_ready ),
        .lane_data_i ( lane_out    ), .lane_valid_i ( lane_valid ), .lane_pop_o ( lane_pop ),
        .tdata_o, .tkeep_o, .tlast_o, .tdest_o, .tvalid_o, .tready_i,
        .done_valid_o, .done_ready_i
    );

endmodule

// ==== dma_axis_xfer.f ====
design/dma_axis_pkg.sv
design/dma_axis_fifo.sv
design/dma_axis_stream_fork.sv
design/dma_axis_legalizer.sv
design/dma_axis_src_read.sv
design/dma_axis_write.sv
design/dma_axis_xfer.sv
sim/dma_axis_xfer_tb.sv

// ==== sim/dma_axis_xfer_tb.sv ====
`timescale 1ns/1ps

module dma_axis_xfer_tb;
    localparam int unsigned StrbWidth       = 4;
    localparam bit          MaskInvalidData = 1'b1;
    localparam int          NumCmds         = 40;
    localparam int          ClkPeriod       = 40;

    logic                    clk_i, arst_n_i;
    dma_axis_pkg::xfer_cmd_t cmd_i;
    logic                    cmd_valid_i, cmd_ready_o;
    logic [StrbWidth*8-1:0]  src_data_i, tdata_o;
    logic                    src_valid_i, src_ready_o;
    logic [StrbWidth-1:0]    tkeep_o;
    logic                    tlast_o, tvalid_o, tready_i;
    logic [3:0]              tdest_o;
    logic                    done_valid_o, done_ready_i;

    // Stimulus tables and scoreboard state
    dma_axis_pkg::xfer_cmd_t cmds [NumCmds];
    logic [StrbWidth*8-1:0]  src_words [$];
    logic [31:0]             rng;
    int                      src_pos, beat_cmd, beat_idx, byte_idx, done_cnt;
    // Payload seen while the sink was stalling
    logic                    stall_q, done_stall_q;
    logic [StrbWidth*8-1:0]  held_tdata;
    logic [StrbWidth-1:0]    held_tkeep;
    logic                    held_tlast;
    logic [3:0]              held_tdest;

    dma_axis_xfer #(.StrbWidth(StrbWidth), .MaskInvalidData(MaskInvalidData)) i_dma_axis_xfer (
        .clk_i, .arst_n_i, .cmd_i, .cmd_valid_i, .cmd_ready_o,
        .src_data_i, .src_valid_i, .src_ready_o,
        .tdata_o, .tkeep_o, .tlast_o, .tdest_o, .tvalid_o, .tready_i,
        .done_valid_o, .done_ready_i
    );

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Byte j of source word w of command n
    function automatic logic [7:0] src_byte_hash(input int n, input int w, input int j);
        logic [31:0] h;
        h = (32'(n) * 32'h9e37_79b9) ^ (32'(w) * 32'h85eb_ca6b) ^ (32'(j) * 32'h0000_0097);
        h = h ^ (h >> 15);
        h = h * 32'h2c1b_3c6d;
        return h[7:0] ^ h[23:16];
    endfunction

    function automatic int beats_of(input int off, input int len);
        return (off + len + StrbWidth - 1) / StrbWidth;
    endfunction

    // Lanes of destination beat b, from its offset up to its tailer
    function automatic logic [StrbWidth-1:0] expected_keep(input int n, input int b);
        int first, stop, off, len;
        off   = int'(cmds[n].dst_offset);
        len   = int'(cmds[n].length);
        first = (b == 0) ? off : 0;
        stop  = (b == beats_of(off, len) - 1) ? ((off + len - 1) % StrbWidth) + 1 : StrbWidth;
        return StrbWidth'(((1 << stop) - 1) & ~((1 << first) - 1));
    endfunction

    // Byte k of the transfer, as the source model placed it
    function automatic logic [7:0] expected_byte(input int n, input int k);
        int pos;
        pos = int'(cmds[n].src_offset) + k;
        return src_byte_hash(n, pos / StrbWidth, pos % StrbWidth);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        abort_run("Output check did not hold");
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(ClkPeriod / 2) clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin : drive
        logic cmd_fire, src_fire;
        int   cmd_pos;
        logic [StrbWidth*8-1:0] word;
        arst_n_i = 1'b0;
        cmd_i = '0;
        cmd_valid_i = 1'b0;
        src_data_i = '0;
        src_valid_i = 1'b0;
        tready_i = 1'b0;
        done_ready_i = 1'b0;
        cmd_pos = 0;
        src_pos = 0;
        rng = 32'hec5c_4743;
        // Random commands, then every source word they need
        for (int n = 0; n < NumCmds; n++) begin
            rng = xorshift32(rng);
            cmds[n].src_offset = dma_axis_pkg::offset_t'(rng[3:0] % StrbWidth);
            cmds[n].dst_offset = dma_axis_pkg::offset_t'(rng[7:4] % StrbWidth);
            cmds[n].length     = 16'(1 + (rng[23:8] % (3 * StrbWidth)));
            cmds[n].dest       = rng[27:24];
            for (int w = 0; w < beats_of(cmds[n].src_offset, cmds[n].length); w++) begin
                for (int j = 0; j < StrbWidth; j++) word[j*8 +: 8] = src_byte_hash(n, w, j);
                src_words.push_back(word);
            end
        end
        repeat (16) @(posedge clk_i);
        #2;
        arst_n_i = 1'b1;
        forever begin
            // Handshakes read mid-cycle, where inputs and outputs are settled
            @(negedge clk_i);
            cmd_fire = cmd_valid_i & cmd_ready_o;
            src_fire = src_valid_i & src_ready_o;
            @(posedge clk_i);
            #2;
            if (cmd_fire) cmd_pos++;
            if (src_fire) src_pos++;
            cmd_valid_i = (cmd_pos < NumCmds);
            cmd_i = (cmd_pos < NumCmds) ? cmds[cmd_pos] : '0;
            rng = xorshift32(rng);
            // A pending source word stays put until taken
            if (!src_valid_i || src_fire) begin
                src_valid_i = (src_pos < src_words.size()) && (rng[9:8] != 2'b00);
                src_data_i = (src_pos < src_words.size()) ? src_words[src_pos] : '0;
            end
            tready_i = (rng[1:0] != 2'b00);
            done_ready_i = (rng[5:4] != 2'b00);
        end
    end

    // ----------------------------------------
    // Output checks
    // ----------------------------------------
    // Sampled on the falling edge, one half period clear of every update
    always @(negedge clk_i) begin : monitor
        if (!arst_n_i) begin
            assert (!tvalid_o) else report_mismatch("tvalid_o", tvalid_o, 0);
            assert (!done_valid_o) else report_mismatch("done_valid_o", done_valid_o, 0);
            assert (cmd_ready_o) else report_mismatch("cmd_ready_o", cmd_ready_o, 1);
            assert (!src_ready_o) else report_mismatch("src_ready_o", src_ready_o, 0);
            stall_q = 1'b0;
            done_stall_q = 1'b0;
            beat_cmd = 0;
            beat_idx = 0;
            byte_idx = 0;
            done_cnt = 0;
        end else begin
            // Stalled beats keep valid and payload
            if (stall_q) begin
                assert (tvalid_o) else report_mismatch("tvalid_o", tvalid_o, 1);
                assert (tdata_o == held_tdata) else report_mismatch("tdata_o", tdata_o, held_tdata);
                assert (tkeep_o == held_tkeep) else report_mismatch("tkeep_o", tkeep_o, held_tkeep);
                assert (tlast_o == held_tlast) else report_mismatch("tlast_o", tlast_o, held_tlast);
                assert (tdest_o == held_tdest) else report_mismatch("tdest_o", tdest_o, held_tdest);
            end
            if (done_stall_q) begin
                assert (done_valid_o) else report_mismatch("done_valid_o", done_valid_o, 1);
            end
            // Done in order, never ahead of its last beat
            if (done_valid_o && done_ready_i) begin
                assert (done_cnt < NumCmds) else abort_run("More done transfers than commands");
                assert ((done_cnt < beat_cmd) || (tvalid_o && tlast_o && done_cnt == beat_cmd))
                    else abort_run("Done transfer came before the last stream beat");
                done_cnt++;
            end
            if (tvalid_o) begin
                assert (beat_cmd < NumCmds) else abort_run("Stream beat after all transfers");
                assert (tkeep_o == expected_keep(beat_cmd, beat_idx))
                    else report_mismatch("tkeep_o", tkeep_o, expected_keep(beat_cmd, beat_idx));
                assert (tlast_o == (beat_idx == beats_of(cmds[beat_cmd].dst_offset,
                                                         cmds[beat_cmd].length) - 1))
                    else report_mismatch("tlast_o", tlast_o, !tlast_o);
                assert (tdest_o == cmds[beat_cmd].dest)
                    else report_mismatch("tdest_o", tdest_o, cmds[beat_cmd].dest);
                for (int j = 0; j < StrbWidth; j++) begin
                    if (MaskInvalidData && !tkeep_o[j]) begin
                        assert (tdata_o[j*8 +: 8] == 8'h00)
                            else report_mismatch($sformatf("tdata_o[%0d]", j), tdata_o[j*8 +: 8], 0);
                    end
                end
                if (tready_i) begin
                    // Kept bytes walk the transfer in order
                    for (int j = 0; j < StrbWidth; j++) begin
                        if (tkeep_o[j]) begin
                            assert (tdata_o[j*8 +: 8] == expected_byte(beat_cmd, byte_idx))
                                else report_mismatch($sformatf("tdata_o[%0d]", j),
                                    tdata_o[j*8 +: 8], expected_byte(beat_cmd, byte_idx));
                            byte_idx++;
                        end
                    end
                    if (tlast_o) begin
                        beat_cmd++;
                        beat_idx = 0;
                        byte_idx = 0;
                    end else begin
                        beat_idx++;
                    end
                end
            end
            stall_q = tvalid_o && !tready_i;
            done_stall_q = done_valid_o && !done_ready_i;
            held_tdata = tdata_o;
            held_tkeep = tkeep_o;
            held_tlast = tlast_o;
            held_tdest = tdest_o;
        end
    end

    // Ends the run once every command has its done
    initial begin
        wait (arst_n_i === 1'b1 && done_cnt == NumCmds);
        repeat (20) @(posedge clk_i);
        if (beat_cmd == NumCmds && done_cnt == NumCmds && src_pos == src_words.size()) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            abort_run("Stream beats or source words left over after the last done");
        end
    end

    initial begin
        #(ClkPeriod * (16 + NumCmds * 400));
        abort_run("Timeout: transfers did not complete in time");
    end

endmodule
